//--- Makefile
VERILATOR ?= verilator
TOP       ?= cpu_control_tb
FILELIST  ?= cpu_control.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := include/cpu_control_settings.svh
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "Regression passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- cpu_control.f
+incdir+include
verilog/cpu_control_pkg.sv
verilog/instr_decode.sv
verilog/micro_sequencer.sv
verilog/control_outputs.sv
verilog/cpu_control.sv
verification/cpu_control_sva.sv
verification/cpu_control_tb.sv

//--- include/cpu_control_settings.svh
`ifndef CPU_CONTROL_SETTINGS_SVH
`define CPU_CONTROL_SETTINGS_SVH

`define CPU_IR_MODE_MSB 31
`define CPU_IR_MODE_LSB 29
`define CPU_IR_OP_MSB   28
`define CPU_IR_OP_LSB   21
`define CPU_IR_RA_MSB   20
`define CPU_IR_RA_LSB   16
`define CPU_IR_RB_MSB   15
`define CPU_IR_RB_LSB   11
`define CPU_IR_RC_MSB   10
`define CPU_IR_RC_LSB   6

`define CPU_MODE_REG    3'h0
`define CPU_MODE_REGIND 3'h1
`define CPU_MODE_IMM    3'h2

// register mode
`define CPU_OP_NOP      8'h00
`define CPU_OP_CMP      8'h02
`define CPU_OP_INC      8'h03
`define CPU_OP_DEC      8'h04
`define CPU_OP_MOV      8'h07
`define CPU_OP_COM      8'h08
`define CPU_OP_NEG      8'h09
`define CPU_OP_ALU      8'h20
`define CPU_OP_ALU_MASK 8'hf0

// immediate mode
`define CPU_OP_BRA      8'h00
`define CPU_OP_BEQ      8'h01
`define CPU_OP_BNE      8'h02
`define CPU_OP_BGTU     8'h03
`define CPU_OP_BGT      8'h04
`define CPU_OP_BGE      8'h05
`define CPU_OP_BLE      8'h06
`define CPU_OP_BLT      8'h07
`define CPU_OP_BGEU     8'h08
`define CPU_OP_BLTU     8'h09
`define CPU_OP_BLEU     8'h0a
`define CPU_OP_BRN      8'h0b
`define CPU_OP_LDIS     8'h0c
`define CPU_OP_LDIU     8'h0d

// register indirect mode
`define CPU_OP_ST_W     8'h00
`define CPU_OP_LD_W     8'h01
`define CPU_OP_ST_H     8'h02
`define CPU_OP_LD_H     8'h03
`define CPU_OP_ST_B     8'h04
`define CPU_OP_LD_B     8'h05
`define CPU_OP_LDA      8'h0a
`define CPU_OP_JMP      8'h0b

`define CPU_BE_WORD     4'b1111

`define CPU_ALU_ADD     3'h2
`define CPU_ALU_SUB     3'h3
`define CPU_ALU2_REG    3'h0
`define CPU_ALU2_IND    3'h1
`define CPU_ALU2_ONE    3'h2
`define CPU_REGSEL_ALU  3'h0
`define CPU_REGSEL_MDR  3'h1
`define CPU_REGSEL_NEG  3'h2
`define CPU_REGSEL_COM  3'h3
`define CPU_REGSEL_RB   3'h4
`define CPU_REGSEL_IMMS 3'h5
`define CPU_REGSEL_IMMU 3'h6
`define CPU_MDR_HOLD    3'h0
`define CPU_MDR_BUS     3'h1
`define CPU_MDR_RA      3'h3
`define CPU_MAR_HOLD    2'h0
`define CPU_MAR_ALU     2'h2
`define CPU_PC_HOLD     3'h0
`define CPU_PC_ADVANCE  3'h1
`define CPU_PC_REL      3'h3
`define CPU_PC_ALU      3'h4
`define CPU_REG_WR_NONE 2'b00
`define CPU_REG_WR_WORD 2'b11

`endif

//--- verification/cpu_control_sva.sv
`timescale 1ns/100ps
`include "cpu_control_settings.svh"

module cpu_control_sva (
  input logic                        clock,
  input logic                        reset_n,
  input logic                        bus_wait,
  input logic                        bus_access,
  input logic                        bus_read,
  input logic                        bus_write,
  input logic                        ir_write,
  input logic                        ccr_write,
  input cpu_control_pkg::pc_sel_t    pcsel,
  input cpu_control_pkg::reg_write_t reg_write,
  input cpu_control_pkg::byte_en_t   byteenable,
  input cpu_control_pkg::phase_t     phase,
  input cpu_control_pkg::step_t      step
);

  int failures = 0;  // read by the testbench at the end

  // a stretched step keeps its whole control word
  a_stall_stable: assert property (@(posedge clock) disable iff (!reset_n)
    bus_access && bus_wait |=>
      $stable({bus_read, bus_write, ir_write, byteenable, reg_write, pcsel}))
    else begin
      $error("control outputs changed during a bus stall");
      failures++;
    end

  a_fetch_ir: assert property (@(posedge clock) disable iff (!reset_n)
    (phase == cpu_control_pkg::ph_fetch) && (step == '0) && !bus_wait |=> ir_write)
    else begin
      $error("ir_write missing after completed fetch read");
      failures++;
    end

  a_pc_advance: assert property (@(posedge clock) disable iff (!reset_n)
    ir_write |=> pcsel == `CPU_PC_ADVANCE)
    else begin
      $error("pc advance missing after ir_write");
      failures++;
    end

  // reset and fault phases leave the datapath idle
  a_idle_quiet: assert property (@(posedge clock) disable iff (!reset_n)
    (phase == cpu_control_pkg::ph_reset) || (phase == cpu_control_pkg::ph_fault) |->
      !bus_read && !bus_write && !ir_write && !ccr_write &&
      (reg_write == `CPU_REG_WR_NONE) && (pcsel == `CPU_PC_HOLD) &&
      (byteenable == `CPU_BE_WORD))
    else begin
      $error("active control output in reset or fault phase");
      failures++;
    end

  a_fault_sticky: assert property (@(posedge clock) disable iff (!reset_n)
    phase == cpu_control_pkg::ph_fault |=> phase == cpu_control_pkg::ph_fault)
    else begin
      $error("fault phase left without reset");
      failures++;
    end

  // fetch follows the single reset cycle
  a_first_fetch: assert property (@(posedge clock) disable iff (!reset_n)
    phase == cpu_control_pkg::ph_reset |=> bus_read)
    else begin
      $error("bus_read missing after the reset phase");
      failures++;
    end

endmodule

bind cpu_control cpu_control_sva cpu_control_sva_inst (.*);

//--- verification/cpu_control_tb.sv
`timescale 1ns/100ps
`include "cpu_control_settings.svh"

module cpu_control_tb;

  logic                        clock;
  logic                        reset_n;
  cpu_control_pkg::instr_t     ir;
  cpu_control_pkg::ccr_t       ccr;
  logic                        bus_wait;
  cpu_control_pkg::bus_align_t bus_align;
  logic                        ir_write;
  logic                        ccr_write;
  cpu_control_pkg::alu_func_t  alu_func;
  cpu_control_pkg::alu2_sel_t  alu2sel;
  cpu_control_pkg::reg_sel_t   regsel;
  cpu_control_pkg::reg_addr_t  reg_read_addr1;
  cpu_control_pkg::reg_addr_t  reg_read_addr2;
  cpu_control_pkg::reg_addr_t  reg_write_addr;
  cpu_control_pkg::reg_write_t reg_write;
  cpu_control_pkg::mdr_sel_t   mdrsel;
  cpu_control_pkg::mar_sel_t   marsel;
  cpu_control_pkg::pc_sel_t    pcsel;
  logic                        addrsel;
  logic                        bus_read;
  logic                        bus_write;
  cpu_control_pkg::byte_en_t   byteenable;

  integer                  seed = 32'ha229f9d5;
  int                      errors = 0;
  int                      tests = 0;
  int                      mark;
  int                      wait_left = 0;
  logic                    busy = 1'b0;
  cpu_control_pkg::instr_t next_ir = '0;
  cpu_control_pkg::ccr_t   next_ccr = '0;

  cpu_control cpu_control_inst (.*);

  always #5 clock = ~clock;

  // bus model, random wait per access, align only moves between accesses
  always @(negedge clock) begin
    if (bus_read || bus_write) begin
      if (!busy) begin
        wait_left = $unsigned($random(seed)) % 4;
        busy = 1'b1;
      end
      bus_wait <= (wait_left != 0);
      if (wait_left != 0)
        wait_left = wait_left - 1;
    end else begin
      busy = 1'b0;
      bus_wait <= 1'b0;
      bus_align <= 2'($random(seed));
    end
  end

  always @(negedge clock) begin
    if (ir_write) begin  // next instruction from the feeder
      ir  <= next_ir;
      ccr <= next_ccr;
    end
  end

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    assert (actual === expected) else begin
      $display("ERR %0t %s actual %0h expected %0h", $time, name, actual, expected);
      errors++;
    end
  endtask

  task automatic sample;
    @(negedge clock);
    #1;
  endtask

  task automatic fail_now(input string what);
    $display("%s", what);
    $display("Regression failed");
    $finish;
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %s done, %0d errors", name, errors - mark);
    mark = errors;
  endtask

  task automatic check_idle;
    check("bus_read", bus_read, 0);
    check("bus_write", bus_write, 0);
    check("ir_write", ir_write, 0);
    check("ccr_write", ccr_write, 0);
    check("reg_write", reg_write, `CPU_REG_WR_NONE);
    check("pcsel", pcsel, `CPU_PC_HOLD);
    check("byteenable", byteenable, `CPU_BE_WORD);
  endtask

  function automatic cpu_control_pkg::instr_t make_instr(input logic [2:0] mode,
      input logic [7:0] op, input logic [4:0] ra, input logic [4:0] rb,
      input logic [4:0] rc);
    return {mode, op, ra, rb, rc, 6'h00};
  endfunction

  function automatic logic branch_expect(input logic [7:0] op, input logic [3:0] f);
    logic c;
    logic n;
    logic v;
    logic z;
    {c, n, v, z} = f;
    case (op)
      `CPU_OP_BRA:  return 1'b1;
      `CPU_OP_BEQ:  return z;
      `CPU_OP_BNE:  return !z;
      `CPU_OP_BGTU: return !(z || c);
      `CPU_OP_BGT:  return !(z || (n != v));
      `CPU_OP_BGE:  return n == v;
      `CPU_OP_BLE:  return z || (n != v);
      `CPU_OP_BLT:  return n != v;
      `CPU_OP_BGEU: return !c;
      `CPU_OP_BLTU: return c;
      `CPU_OP_BLEU: return c || z;
      default:      return 1'b0;
    endcase
  endfunction

  // lane 0 is the top byte
  function automatic logic [3:0] lane_expect(input int size, input logic [1:0] align);
    if (size == 0)
      return 4'b1111;
    if (size == 1)
      return (align < 2) ? 4'b1100 : 4'b0011;
    case (align)
      2'd0:    return 4'b1000;
      2'd1:    return 4'b0100;
      2'd2:    return 4'b0010;
      default: return 4'b0001;
    endcase
  endfunction

  // feeds one instruction and follows its fetch up to pc advance
  task automatic issue(input cpu_control_pkg::instr_t instr, input logic [3:0] flags);
    int   n;
    logic done_prev;
    next_ir = instr;
    next_ccr = flags;
    done_prev = 1'b0;
    n = 0;
    sample;
    while (!ir_write) begin
      check("ir_write", ir_write, done_prev);
      check("bus_read", bus_read, 1);  // read held until the bus completes
      check("addrsel", addrsel, 0);
      check("ccr_write", ccr_write, 0);
      done_prev = bus_read && !bus_wait;
      n++;
      if (n > 30)
        fail_now("timeout while waiting for ir_write");
      sample;
    end
    check("ir_write timing", done_prev, 1);
    sample;
    check("pcsel", pcsel, `CPU_PC_ADVANCE);
  endtask

  task automatic reset_dut;
    reset_n = 1'b0;  // caller is on a falling edge
    repeat (10) begin
      #1;
      check_idle;
      @(negedge clock);
    end
    reset_n = 1'b1;
    #1;
    check_idle;  // one idle cycle in the reset phase
  endtask

  initial begin
    logic [4:0] ra;
    logic [4:0] rb;
    logic [4:0] rc;
    logic [3:0] flags;
    int         n;
    clock = 1'b0;
    reset_n = 1'b0;
    ir = '0;
    ccr = '0;
    bus_wait = 1'b0;
    bus_align = '0;
    mark = 0;
    reset_dut;
    issue(make_instr(`CPU_MODE_REG, `CPU_OP_NOP, 5'd0, 5'd0, 5'd0), 4'h0);
    sample;
    check("reg_write", reg_write, `CPU_REG_WR_NONE);
    end_test("reset and first fetch");
    for (int f = 0; f < 8; f++) begin
      ra = 5'($random(seed));
      rb = 5'($random(seed));
      rc = 5'($random(seed));
      issue(make_instr(`CPU_MODE_REG, `CPU_OP_ALU | 8'(f), ra, rb, rc), 4'h0);
      sample;
      check("alu_func", alu_func, f);
      check("reg_read_addr1", reg_read_addr1, rb);
      check("reg_read_addr2", reg_read_addr2, rc);
      check("reg_write", reg_write, `CPU_REG_WR_NONE);
      sample;
      check("reg_write", reg_write, `CPU_REG_WR_WORD);
      check("reg_write_addr", reg_write_addr, ra);
      check("regsel", regsel, `CPU_REGSEL_ALU);
    end
    issue(make_instr(`CPU_MODE_REG, `CPU_OP_CMP, 5'd1, 5'd2, 5'd0), 4'h0);
    sample;
    check("ccr_write", ccr_write, 1);
    check("alu_func", alu_func, `CPU_ALU_SUB);
    check("reg_write", reg_write, `CPU_REG_WR_NONE);
    issue(make_instr(`CPU_MODE_REG, `CPU_OP_NOP, 5'd0, 5'd0, 5'd0), 4'h0);
    sample;
    end_test("register operations");
    for (int op = 0; op < 12; op++) begin
      repeat (3) begin
        flags = 4'($random(seed));
        issue(make_instr(`CPU_MODE_IMM, 8'(op), 5'd0, 5'd0, 5'd0), flags);
        sample;
        check("pcsel", pcsel, branch_expect(8'(op), flags) ? `CPU_PC_REL : `CPU_PC_HOLD);
      end
    end
    end_test("branches");
    // opcode bit 0 selects load, bits 2:1 the size
    for (int k = 0; k < 6; k++) begin
      repeat (4) begin
        ra = 5'($random(seed));
        issue(make_instr(`CPU_MODE_REGIND, 8'(k), ra, 5'd3, 5'd0), 4'h0);
        sample;
        check("reg_read_addr1", reg_read_addr1, 5'd3);  // base register
        check("alu2sel", alu2sel, `CPU_ALU2_IND);
        sample;
        check("marsel", marsel, `CPU_MAR_ALU);
        n = 0;
        sample;
        forever begin
          check(k[0] ? "bus_read" : "bus_write", k[0] ? bus_read : bus_write, 1);
          check(k[0] ? "bus_write" : "bus_read", k[0] ? bus_write : bus_read, 0);
          check("byteenable", byteenable, lane_expect(k / 2, bus_align));
          check("addrsel", addrsel, 1);
          check("mdrsel", mdrsel, k[0] ? `CPU_MDR_BUS : `CPU_MDR_RA);
          if (!bus_wait)
            break;
          n++;
          if (n > 10)
            fail_now("timeout while waiting for the data access to complete");
          sample;
        end
        sample;
        check("reg_write", reg_write, k[0] ? `CPU_REG_WR_WORD : `CPU_REG_WR_NONE);
        check("reg_write_addr", reg_write_addr, ra);
        if (k[0])
          check("regsel", regsel, `CPU_REGSEL_MDR);
      end
    end
    end_test("indirect loads and stores");
    issue(make_instr(3'h3, 8'h00, 5'd0, 5'd0, 5'd0), 4'h0);
    repeat (50) begin
      sample;
      check("bus_read", bus_read, 0);
      check("bus_write", bus_write, 0);
      check("reg_write", reg_write, `CPU_REG_WR_NONE);
    end
    next_ir = make_instr(`CPU_MODE_REG, `CPU_OP_NOP, 5'd0, 5'd0, 5'd0);
    @(negedge clock);
    reset_dut;
    issue(next_ir, 4'h0);
    end_test("illegal opcode");
    errors += cpu_control_inst.cpu_control_sva_inst.failures;  // bound checker
    $display("tests %0d, errors %0d", tests, errors);
    if (errors == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

//--- verilog/control_outputs.sv
`timescale 1ns/100ps
`include "cpu_control_settings.svh"

module control_outputs (
  input  cpu_control_pkg::phase_t     phase,
  input  cpu_control_pkg::step_t      step,
  input  cpu_control_pkg::op_class_t  op_class,
  input  cpu_control_pkg::alu_func_t  alu_op,
  input  cpu_control_pkg::reg_addr_t  ra,
  input  cpu_control_pkg::reg_addr_t  rb,
  input  cpu_control_pkg::reg_addr_t  rc,
  input  logic                        branch_taken,
  input  cpu_control_pkg::bus_align_t bus_align,
  output logic                        ir_write,
  output logic                        ccr_write,
  output cpu_control_pkg::alu_func_t  alu_func,
  output cpu_control_pkg::alu2_sel_t  alu2sel,
  output cpu_control_pkg::reg_sel_t   regsel,
  output cpu_control_pkg::reg_addr_t  reg_read_addr1,
  output cpu_control_pkg::reg_addr_t  reg_read_addr2,
  output cpu_control_pkg::reg_addr_t  reg_write_addr,
  output cpu_control_pkg::reg_write_t reg_write,
  output cpu_control_pkg::mdr_sel_t   mdrsel,
  output cpu_control_pkg::mar_sel_t   marsel,
  output cpu_control_pkg::pc_sel_t    pcsel,
  output logic                        addrsel,
  output logic                        bus_read,
  output logic                        bus_write,
  output cpu_control_pkg::byte_en_t   byteenable,
  output logic                        bus_access,
  output logic                        last_step
);

  cpu_control_pkg::byte_en_t lane_mask;
  logic                      is_load;

  assign is_load = (op_class == cpu_control_pkg::op_load_word) ||
                   (op_class == cpu_control_pkg::op_load_half) ||
                   (op_class == cpu_control_pkg::op_load_byte);

  // lanes are numbered big endian from address 0
  always_comb begin
    case (op_class)
      cpu_control_pkg::op_load_byte,
      cpu_control_pkg::op_store_byte: lane_mask = 4'b1000 >> bus_align;
      cpu_control_pkg::op_load_half,
      cpu_control_pkg::op_store_half: lane_mask = bus_align[1] ? 4'b0011 : 4'b1100;
      default:                        lane_mask = `CPU_BE_WORD;
    endcase
  end

  always_comb begin
    ir_write       = 1'b0;
    ccr_write      = 1'b0;
    alu_func       = `CPU_ALU_ADD;
    alu2sel        = `CPU_ALU2_REG;
    regsel         = `CPU_REGSEL_ALU;
    reg_read_addr1 = ra;
    reg_read_addr2 = rb;
    reg_write_addr = ra;
    reg_write      = `CPU_REG_WR_NONE;
    mdrsel         = `CPU_MDR_HOLD;
    marsel         = `CPU_MAR_HOLD;
    pcsel          = `CPU_PC_HOLD;
    addrsel        = 1'b0;  // address from pc
    bus_read       = 1'b0;
    bus_write      = 1'b0;
    byteenable     = `CPU_BE_WORD;
    bus_access     = 1'b0;
    last_step      = 1'b0;
    if (phase == cpu_control_pkg::ph_fetch) begin
      case (step)
        3'h0: begin
          bus_read   = 1'b1;
          bus_access = 1'b1;  // wait for the bus here
        end
        3'h1: begin
          bus_read = 1'b1;
          ir_write = 1'b1;    // latch instruction
        end
        default: begin
          pcsel     = `CPU_PC_ADVANCE;
          last_step = 1'b1;
        end
      endcase
    end else if (phase == cpu_control_pkg::ph_execute) begin
      case (op_class)
        cpu_control_pkg::op_nop: last_step = 1'b1;
        cpu_control_pkg::op_cmp: begin
          alu_func  = `CPU_ALU_SUB;
          ccr_write = 1'b1;
          last_step = 1'b1;
        end
        cpu_control_pkg::op_inc,
        cpu_control_pkg::op_dec: begin
          if (step == 3'h0) begin
            alu2sel = `CPU_ALU2_ONE;  // ra +/- 1
            if (op_class == cpu_control_pkg::op_dec)
              alu_func = `CPU_ALU_SUB;
          end else begin
            reg_write = `CPU_REG_WR_WORD;
            last_step = 1'b1;
          end
        end
        cpu_control_pkg::op_mov,
        cpu_control_pkg::op_com,
        cpu_control_pkg::op_neg,
        cpu_control_pkg::op_ldis,
        cpu_control_pkg::op_ldiu: begin
          case (op_class)
            cpu_control_pkg::op_mov:  regsel = `CPU_REGSEL_RB;
            cpu_control_pkg::op_com:  regsel = `CPU_REGSEL_COM;
            cpu_control_pkg::op_neg:  regsel = `CPU_REGSEL_NEG;
            cpu_control_pkg::op_ldis: regsel = `CPU_REGSEL_IMMS;
            default:                  regsel = `CPU_REGSEL_IMMU;
          endcase
          reg_write = `CPU_REG_WR_WORD;
          last_step = 1'b1;
        end
        cpu_control_pkg::op_alu: begin
          alu_func       = alu_op;
          reg_read_addr1 = rb;
          reg_read_addr2 = rc;
          if (step != 3'h0) begin
            reg_write = `CPU_REG_WR_WORD;
            last_step = 1'b1;
          end
        end
        cpu_control_pkg::op_branch: begin
          if (branch_taken)
            pcsel = `CPU_PC_REL;
          last_step = 1'b1;
        end
        cpu_control_pkg::op_lda,
        cpu_control_pkg::op_jmp: begin
          if (step == 3'h0) begin
            reg_read_addr1 = rb;
            alu2sel        = `CPU_ALU2_IND;  // rb + offset
          end else begin
            if (op_class == cpu_control_pkg::op_jmp)
              pcsel = `CPU_PC_ALU;
            else
              reg_write = `CPU_REG_WR_WORD;
            last_step = 1'b1;
          end
        end
        cpu_control_pkg::op_load_word,
        cpu_control_pkg::op_load_half,
        cpu_control_pkg::op_load_byte,
        cpu_control_pkg::op_store_word,
        cpu_control_pkg::op_store_half,
        cpu_control_pkg::op_store_byte: begin
          addrsel = 1'b1;  // address from mar
          case (step)
            3'h0: begin
              reg_read_addr1 = rb;
              alu2sel        = `CPU_ALU2_IND;
            end
            3'h1: marsel = `CPU_MAR_ALU;
            3'h2: begin
              bus_read   = is_load;
              bus_write  = ~is_load;
              mdrsel     = is_load ? `CPU_MDR_BUS : `CPU_MDR_RA;
              byteenable = lane_mask;
              bus_access = 1'b1;
            end
            default: begin
              if (is_load) begin
                regsel    = `CPU_REGSEL_MDR;
                reg_write = `CPU_REG_WR_WORD;
              end
              last_step = 1'b1;
            end
          endcase
        end
        default: last_step = 1'b0;  // illegal, sequencer goes to fault
      endcase
    end
  end

endmodule

//--- verilog/cpu_control.sv
`timescale 1ns/100ps

module cpu_control (
  input  logic                        clock,
  input  logic                        reset_n,
  input  cpu_control_pkg::instr_t     ir,
  input  cpu_control_pkg::ccr_t       ccr,
  input  logic                        bus_wait,
  input  cpu_control_pkg::bus_align_t bus_align,
  output logic                        ir_write,
  output logic                        ccr_write,
  output cpu_control_pkg::alu_func_t  alu_func,
  output cpu_control_pkg::alu2_sel_t  alu2sel,
  output cpu_control_pkg::reg_sel_t   regsel,
  output cpu_control_pkg::reg_addr_t  reg_read_addr1,
  output cpu_control_pkg::reg_addr_t  reg_read_addr2,
  output cpu_control_pkg::reg_addr_t  reg_write_addr,
  output cpu_control_pkg::reg_write_t reg_write,
  output cpu_control_pkg::mdr_sel_t   mdrsel,
  output cpu_control_pkg::mar_sel_t   marsel,
  output cpu_control_pkg::pc_sel_t    pcsel,
  output logic                        addrsel,
  output logic                        bus_read,
  output logic                        bus_write,
  output cpu_control_pkg::byte_en_t   byteenable
);

  cpu_control_pkg::op_class_t op_class;
  cpu_control_pkg::alu_func_t alu_op;
  cpu_control_pkg::reg_addr_t ra;
  cpu_control_pkg::reg_addr_t rb;
  cpu_control_pkg::reg_addr_t rc;
  logic                       branch_taken;
  cpu_control_pkg::phase_t    phase;
  cpu_control_pkg::step_t     step;
  logic                       bus_access;
  logic                       last_step;

  instr_decode instr_decode_inst (
    .ir           (ir),
    .ccr          (ccr),
    .op_class     (op_class),
    .alu_op       (alu_op),
    .ra           (ra),
    .rb           (rb),
    .rc           (rc),
    .branch_taken (branch_taken)
  );

  micro_sequencer micro_sequencer_inst (
    .clock      (clock),
    .reset_n    (reset_n),
    .op_class   (op_class),
    .bus_wait   (bus_wait),
    .bus_access (bus_access),
    .last_step  (last_step),
    .phase      (phase),
    .step       (step)
  );

  control_outputs control_outputs_inst (
    .phase          (phase),
    .step           (step),
    .op_class       (op_class),
    .alu_op         (alu_op),
    .ra             (ra),
    .rb             (rb),
    .rc             (rc),
    .branch_taken   (branch_taken),
    .bus_align      (bus_align),
    .ir_write       (ir_write),
    .ccr_write      (ccr_write),
    .alu_func       (alu_func),
    .alu2sel        (alu2sel),
    .regsel         (regsel),
    .reg_read_addr1 (reg_read_addr1),
    .reg_read_addr2 (reg_read_addr2),
    .reg_write_addr (reg_write_addr),
    .reg_write      (reg_write),
    .mdrsel         (mdrsel),
    .marsel         (marsel),
    .pcsel          (pcsel),
    .addrsel        (addrsel),
    .bus_read       (bus_read),
    .bus_write      (bus_write),
    .byteenable     (byteenable),
    .bus_access     (bus_access),
    .last_step      (last_step)
  );

endmodule

//--- verilog/cpu_control_pkg.sv
package cpu_control_pkg;

  typedef logic [31:0] instr_t;
  typedef logic [3:0]  ccr_t;        // carry, negative, overflow, zero
  typedef logic [4:0]  reg_addr_t;
  typedef logic [2:0]  step_t;
  typedef logic [2:0]  alu_func_t;
  typedef logic [2:0]  alu2_sel_t;
  typedef logic [2:0]  reg_sel_t;
  typedef logic [2:0]  mdr_sel_t;
  typedef logic [1:0]  mar_sel_t;
  typedef logic [2:0]  pc_sel_t;
  typedef logic [1:0]  reg_write_t;  // none or full word
  typedef logic [3:0]  byte_en_t;
  typedef logic [1:0]  bus_align_t;

  typedef enum logic [1:0] {
    ph_reset,
    ph_fetch,
    ph_execute,
    ph_fault
  } phase_t;

  // one class per kept instruction or instruction group
  typedef enum logic [4:0] {
    op_nop,
    op_cmp,
    op_inc,
    op_dec,
    op_mov,
    op_com,
    op_neg,
    op_alu,
    op_branch,
    op_ldis,
    op_ldiu,
    op_lda,
    op_jmp,
    op_load_word,
    op_load_half,
    op_load_byte,
    op_store_word,
    op_store_half,
    op_store_byte,
    op_illegal
  } op_class_t;

endpackage

//--- verilog/instr_decode.sv
`timescale 1ns/100ps
`include "cpu_control_settings.svh"

module instr_decode (
  input  cpu_control_pkg::instr_t    ir,
  input  cpu_control_pkg::ccr_t      ccr,
  output cpu_control_pkg::op_class_t op_class,
  output cpu_control_pkg::alu_func_t alu_op,
  output cpu_control_pkg::reg_addr_t ra,
  output cpu_control_pkg::reg_addr_t rb,
  output cpu_control_pkg::reg_addr_t rc,
  output logic                       branch_taken
);

  logic [2:0] mode;
  logic [7:0] op;
  logic       carry;
  logic       negative;
  logic       overflow;
  logic       zero;
  logic       signed_lt;

  assign mode = ir[`CPU_IR_MODE_MSB:`CPU_IR_MODE_LSB];
  assign op   = ir[`CPU_IR_OP_MSB:`CPU_IR_OP_LSB];
  assign ra   = ir[`CPU_IR_RA_MSB:`CPU_IR_RA_LSB];
  assign rb   = ir[`CPU_IR_RB_MSB:`CPU_IR_RB_LSB];
  assign rc   = ir[`CPU_IR_RC_MSB:`CPU_IR_RC_LSB];

  assign alu_op = op[2:0];  // alu group function in low opcode bits

  assign {carry, negative, overflow, zero} = ccr;
  assign signed_lt = negative ^ overflow;

  always_comb begin
    op_class = cpu_control_pkg::op_illegal;  // anything unmatched faults
    case (mode)
      `CPU_MODE_REG: begin
        case (op)
          `CPU_OP_NOP: op_class = cpu_control_pkg::op_nop;
          `CPU_OP_CMP: op_class = cpu_control_pkg::op_cmp;
          `CPU_OP_INC: op_class = cpu_control_pkg::op_inc;
          `CPU_OP_DEC: op_class = cpu_control_pkg::op_dec;
          `CPU_OP_MOV: op_class = cpu_control_pkg::op_mov;
          `CPU_OP_COM: op_class = cpu_control_pkg::op_com;
          `CPU_OP_NEG: op_class = cpu_control_pkg::op_neg;
          default: begin
            if ((op & `CPU_OP_ALU_MASK) == `CPU_OP_ALU)
              op_class = cpu_control_pkg::op_alu;
          end
        endcase
      end
      `CPU_MODE_IMM: begin
        if (op == `CPU_OP_LDIS)
          op_class = cpu_control_pkg::op_ldis;
        else if (op == `CPU_OP_LDIU)
          op_class = cpu_control_pkg::op_ldiu;
        else if (op <= `CPU_OP_BRN)
          op_class = cpu_control_pkg::op_branch;  // bra through brn
      end
      `CPU_MODE_REGIND: begin
        case (op)
          `CPU_OP_LD_W: op_class = cpu_control_pkg::op_load_word;
          `CPU_OP_LD_H: op_class = cpu_control_pkg::op_load_half;
          `CPU_OP_LD_B: op_class = cpu_control_pkg::op_load_byte;
          `CPU_OP_ST_W: op_class = cpu_control_pkg::op_store_word;
          `CPU_OP_ST_H: op_class = cpu_control_pkg::op_store_half;
          `CPU_OP_ST_B: op_class = cpu_control_pkg::op_store_byte;
          `CPU_OP_LDA:  op_class = cpu_control_pkg::op_lda;
          `CPU_OP_JMP:  op_class = cpu_control_pkg::op_jmp;
          default:      op_class = cpu_control_pkg::op_illegal;
        endcase
      end
      default: op_class = cpu_control_pkg::op_illegal;
    endcase
  end

  // condition table, only looked at for the branch class
  always_comb begin
    case (op)
      `CPU_OP_BRA:  branch_taken = 1'b1;
      `CPU_OP_BEQ:  branch_taken = zero;
      `CPU_OP_BNE:  branch_taken = ~zero;
      `CPU_OP_BGTU: branch_taken = ~(zero | carry);
      `CPU_OP_BGT:  branch_taken = ~(zero | signed_lt);
      `CPU_OP_BGE:  branch_taken = ~signed_lt;
      `CPU_OP_BLE:  branch_taken = zero | signed_lt;
      `CPU_OP_BLT:  branch_taken = signed_lt;
      `CPU_OP_BGEU: branch_taken = ~carry;
      `CPU_OP_BLTU: branch_taken = carry;
      `CPU_OP_BLEU: branch_taken = carry | zero;
      default:      branch_taken = 1'b0;  // brn and non-branches
    endcase
  end

endmodule

//--- verilog/micro_sequencer.sv
`timescale 1ns/100ps

module micro_sequencer (
  input  logic                       clock,
  input  logic                       reset_n,
  input  cpu_control_pkg::op_class_t op_class,
  input  logic                       bus_wait,
  input  logic                       bus_access,
  input  logic                       last_step,
  output cpu_control_pkg::phase_t    phase,
  output cpu_control_pkg::step_t     step
);

  cpu_control_pkg::phase_t phase_next;
  cpu_control_pkg::step_t  step_next;
  logic                    stall;
  logic                    illegal_start;

  // a pending bus access stretches the current step
  assign stall = bus_access && bus_wait;

  assign illegal_start = (phase == cpu_control_pkg::ph_execute) && (step == '0) &&
                         (op_class == cpu_control_pkg::op_illegal);

  always_comb begin
    phase_next = phase;
    step_next  = step;
    case (phase)
      cpu_control_pkg::ph_reset: begin
        phase_next = cpu_control_pkg::ph_fetch;  // one idle cycle after reset
        step_next  = '0;
      end
      cpu_control_pkg::ph_fetch,
      cpu_control_pkg::ph_execute: begin
        if (illegal_start) begin
          phase_next = cpu_control_pkg::ph_fault;
          step_next  = '0;
        end else if (!stall) begin
          if (last_step) begin
            step_next = '0;
            if (phase == cpu_control_pkg::ph_fetch)
              phase_next = cpu_control_pkg::ph_execute;
            else
              phase_next = cpu_control_pkg::ph_fetch;
          end else begin
            step_next = step + 1'b1;
          end
        end
      end
      cpu_control_pkg::ph_fault: begin
        phase_next = cpu_control_pkg::ph_fault;  // only reset leaves fault
        step_next  = '0;
      end
      default: begin
        phase_next = cpu_control_pkg::ph_fault;
        step_next  = '0;
      end
    endcase
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      phase <= cpu_control_pkg::ph_reset;
      step  <= '0;
    end else begin
      phase <= phase_next;
      step  <= step_next;
    end
  end

endmodule
